// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_uart_loopback
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== design/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo
    import uart_pkg::*;
#(
    // Must be a power of two, pointers wrap naturally
    parameter int fifo_depth = 16
) (
    input  logic       clk_50Mhz,
    input  logic       reset,
    input  uart_byte_t wr_byte,
    input  logic       wr,
    input  logic       rd,
    output uart_byte_t head_byte,
    output logic       not_empty,
    output logic       full
);

    localparam int ptr_w = $clog2(fifo_depth);

    // Storage
    uart_byte_t       mem [fifo_depth];

    // Pointers and occupancy
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    // Qualified requests
    logic             do_wr;
    logic             do_rd;

    // Write when full and read when empty are ignored
    assign do_wr = wr && !full;
    assign do_rd = rd && not_empty;

    //////////////////////////////////////////////////////////////////////
    // Pointer and count update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_50Mhz) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Array write
    always_ff @(posedge clk_50Mhz) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_byte;
        end
    end

    // Head is read straight out, valid a cycle after the write
    assign head_byte = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == (ptr_w + 1)'(fifo_depth));

    // Receiver overran the buffer, byte lost
    no_write_when_full: assert property (
        @(posedge clk_50Mhz) disable iff (reset) wr |-> !full
    ) else $error("byte_fifo: write while full, byte dropped");

    // Pop logic must follow not_empty
    no_read_when_empty: assert property (
        @(posedge clk_50Mhz) disable iff (reset) rd |-> not_empty
    ) else $error("byte_fifo: read while empty");

endmodule

// ==== design/uart_loopback.sv ====
`timescale 1ns/1ps

module uart_loopback
    import uart_pkg::*;
#(
    parameter int clks_per_bit = default_clks_per_bit,
    parameter int fifo_depth   = 16
) (
    input  logic clk_50Mhz,
    input  logic reset,
    input  logic rxd,
    output logic txd
);

    uart_byte_t rx_byte;
    uart_byte_t head_byte;
    logic       rx_strobe;
    logic       not_empty;
    logic       tx_idle;
    logic       load;

    //////////////////////////////////////////////////////////////////////
    // Echo control
    //////////////////////////////////////////////////////////////////////

    // Pop and load together, tx_idle drops next cycle so one pulse only
    assign load = not_empty && tx_idle;

    // Receiver, produces framed bytes
    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_rx (
        .clk_50Mhz (clk_50Mhz),
        .reset     (reset),
        .rxd       (rxd),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    // Queue while the transmitter is busy
    byte_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk_50Mhz (clk_50Mhz),
        .reset     (reset),
        .wr_byte   (rx_byte),
        .wr        (rx_strobe),
        .rd        (load),
        .head_byte (head_byte),
        .not_empty (not_empty),
        // Overflow is caught inside the FIFO
        .full      ()
    );

    // Transmitter, echoes the head byte
    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) u_tx (
        .clk_50Mhz (clk_50Mhz),
        .reset     (reset),
        .tx_byte   (head_byte),
        .load      (load),
        .txd       (txd),
        .tx_idle   (tx_idle)
    );

endmodule

// ==== design/uart_pkg.sv ====
package uart_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////////////////////////

    // One data byte as it travels on the line
    typedef logic [7:0] uart_byte_t;

    //////////////////////////////////////////////////////////////////////
    // Frame format
    //////////////////////////////////////////////////////////////////////

    // Data bits per frame, no parity
    localparam int data_bits = 8;

    // Line level while nothing is sent
    localparam logic line_idle = 1'b1;

    // Start bit pulls the line low
    localparam logic start_level = 1'b0;

    // Single stop bit, high
    localparam logic stop_level = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Baud rate
    //////////////////////////////////////////////////////////////////////

    // 50 MHz / 115200 baud, rounded down
    localparam int default_clks_per_bit = 434;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = default_clks_per_bit
) (
    input  logic       clk_50Mhz,
    input  logic       reset,
    input  logic       rxd,
    output uart_byte_t rx_byte,
    output logic       rx_strobe
);

    // Counter widths
    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(data_bits);

    // Last cycle of a bit period
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    // Middle of the start bit
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'((clks_per_bit - 1) / 2);
    localparam logic [idx_w-1:0] last_idx = idx_w'(data_bits - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       rxd_sync;
    logic             rxd_s;
    logic [cnt_w-1:0] bit_cnt;
    logic [idx_w-1:0] bit_idx;
    uart_byte_t       shift_reg;
    logic             sample_tick;

    //////////////////////////////////////////////////////////////////////
    // Input synchronizer
    //////////////////////////////////////////////////////////////////////

    // Two flops, reset to idle level so no false start
    always_ff @(posedge clk_50Mhz) begin
        if (reset) begin
            rxd_sync <= {2{line_idle}};
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    assign rxd_s = rxd_sync[1];

    // Mid-bit sample point once aligned past the start bit
    assign sample_tick = (bit_cnt == last_cnt);

    //////////////////////////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_50Mhz) begin
        if (reset) begin
            state     <= rx_idle;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            // Strobe lasts one cycle only
            rx_strobe <= 1'b0;
            case (state)
                rx_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    // Falling edge opens a frame
                    if (rxd_s == start_level) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // Glitch, line went back high
                    if (rxd_s != start_level) begin
                        state <= rx_idle;
                    end else if (bit_cnt == half_cnt) begin
                        // Now centred, count full periods from here
                        bit_cnt <= '0;
                        state   <= rx_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (sample_tick) begin
                        bit_cnt <= '0;
                        if (bit_idx == last_idx) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (sample_tick) begin
                        // Bad stop bit drops the frame
                        rx_strobe <= (rxd_s == stop_level);
                        state     <= rx_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // Data path, LSB arrives first so shift in from the top
    always_ff @(posedge clk_50Mhz) begin
        if (state == rx_data && sample_tick) begin
            shift_reg <= {rxd_s, shift_reg[data_bits-1:1]};
        end
        if (state == rx_stop && sample_tick && rxd_s == stop_level) begin
            rx_byte <= shift_reg;
        end
    end

    // Frames are ~10 bit periods apart, strobe can never repeat
    rx_strobe_single: assert property (
        @(posedge clk_50Mhz) disable iff (reset) rx_strobe |=> !rx_strobe
    ) else $error("uart_rx: rx_strobe high on consecutive cycles");

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
#(
    parameter int clks_per_bit = default_clks_per_bit
) (
    input  logic       clk_50Mhz,
    input  logic       reset,
    input  uart_byte_t tx_byte,
    input  logic       load,
    output logic       txd,
    output logic       tx_idle
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam int idx_w = $clog2(data_bits);

    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [idx_w-1:0] last_idx = idx_w'(data_bits - 1);

    typedef enum logic [1:0] {
        tx_wait,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    tx_state_t        state;
    logic [cnt_w-1:0] bit_cnt;
    logic [idx_w-1:0] bit_idx;
    uart_byte_t       shift_reg;
    logic             bit_end;

    // Last cycle of the current bit on the line
    assign bit_end = (bit_cnt == last_cnt);

    //////////////////////////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_50Mhz) begin
        if (reset) begin
            state   <= tx_wait;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= line_idle;
            tx_idle <= 1'b1;
        end else begin
            case (state)
                tx_wait: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    // Start bit on the line next cycle
                    if (load) begin
                        txd     <= start_level;
                        tx_idle <= 1'b0;
                        state   <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        txd     <= shift_reg[0];
                        state   <= tx_data;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_data: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == last_idx) begin
                            txd   <= stop_level;
                            state <= tx_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shift_reg[0];
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                tx_stop: begin
                    // Line stays high, ready for the next byte
                    if (bit_end) begin
                        tx_idle <= 1'b1;
                        state   <= tx_wait;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= tx_wait;
                end
            endcase
        end
    end

    // Byte latch and shifter, LSB goes out first
    always_ff @(posedge clk_50Mhz) begin
        if (state == tx_wait && load) begin
            shift_reg <= tx_byte;
        end else if (bit_end && (state == tx_start || state == tx_data)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    // Load from the top must wait for tx_idle
    load_only_when_idle: assert property (
        @(posedge clk_50Mhz) disable iff (reset) load |-> tx_idle
    ) else $error("uart_tx: load while a frame is in progress");

endmodule

// ==== dv/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 4,
    parameter int drive_delay  = 2
) (
    output logic clk_50Mhz,
    output logic reset
);

    // Free-running clock, low at time zero
    initial begin
        clk_50Mhz = 1'b0;
        forever #(period_ns / 2) clk_50Mhz = ~clk_50Mhz;
    end

    // Reset released just after an edge so it is stable at the next one
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk_50Mhz);
        #(drive_delay);
        reset = 1'b0;
    end

endmodule

// ==== dv/tb_uart_loopback.sv ====
`timescale 1ns/1ps

module tb_uart_loopback
    import uart_pkg::*;
();

    localparam int clks_per_bit  = 16;
    localparam int clk_period_ns = 20;
    localparam int drive_delay   = 2;
    localparam int frame_bits    = data_bits + 2;
    localparam int num_frames    = 16;
    // Quiet line after reset, in bit periods
    localparam int idle_bits     = 30;
    // Longest wait for the last echo after the last stop bit, in clocks
    localparam int drain_limit   = 2 * frame_bits * clks_per_bit;

    // One table row per frame on rxd
    typedef struct packed {
        uart_byte_t data;
        logic       bad_stop;
        logic [7:0] gap;
        logic       echo;
    } frame_t;

    logic       clk_50Mhz;
    logic       reset;
    logic       rxd;
    logic       txd;

    frame_t     frames [num_frames];
    uart_byte_t expected_q [$];
    int         echo_count     = 0;
    int         expected_total = 0;
    int         error_count    = 0;
    longint     limit_ns       = 0;
    logic [31:0] rng_state     = 32'h2b98a60d;

    clock_gen #(
        .period_ns   (clk_period_ns),
        .reset_cycles(4),
        .drive_delay (drive_delay)
    ) u_clock (
        .clk_50Mhz (clk_50Mhz),
        .reset     (reset)
    );

    uart_loopback #(
        .clks_per_bit (clks_per_bit),
        .fifo_depth   (16)
    ) UUT (
        .clk_50Mhz (clk_50Mhz),
        .reset     (reset),
        .rxd       (rxd),
        .txd       (txd)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Advances the shared generator state
    function uart_byte_t rand_byte();
        rng_state = next_random(rng_state);
        return rng_state[7:0];
    endfunction

    function automatic frame_t make_frame(uart_byte_t d, logic bad, int gap, logic echo);
        frame_t f;
        f.data     = d;
        f.bad_stop = bad;
        f.gap      = 8'(gap);
        f.echo     = echo;
        return f;
    endfunction

    task automatic stop_on_error(input string why);
        error_count++;
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 8'h%02h expected 8'h%02h", $time, what, got, exp);
            stop_on_error("echoed data differs from the byte sent");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_error("wrong number of echoed frames");
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_on_error("wrong level on txd");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Serial driver
    //////////////////////////////////////////////////////////////////////

    // One bit held for exactly clks_per_bit cycles
    task automatic drive_bit(input logic level);
        @(posedge clk_50Mhz);
        #(drive_delay);
        rxd = level;
        repeat (clks_per_bit - 1) @(posedge clk_50Mhz);
    endtask

    task automatic send_frame(input frame_t f);
        int i;
        repeat (f.gap) drive_bit(line_idle);
        // Queued before the start bit, so it is there ahead of its echo
        if (f.echo) begin
            expected_q.push_back(f.data);
        end
        drive_bit(start_level);
        for (i = 0; i < data_bits; i++) begin
            drive_bit(f.data[i]);
        end
        if (f.bad_stop) begin
            drive_bit(~stop_level);
            // Back to idle so the low stop bit ends
            drive_bit(line_idle);
        end else begin
            drive_bit(stop_level);
        end
    endtask

    task automatic build_table();
        // Lone byte after a long gap
        frames[0]  = make_frame(8'ha5, 1'b0, 20, 1'b1);
        // Back-to-back burst, queue builds while tx is busy
        frames[1]  = make_frame(8'h12, 1'b0, 4, 1'b1);
        frames[2]  = make_frame(rand_byte(), 1'b0, 0, 1'b1);
        frames[3]  = make_frame(8'h9c, 1'b0, 0, 1'b1);
        frames[4]  = make_frame(rand_byte(), 1'b0, 0, 1'b1);
        frames[5]  = make_frame(8'h01, 1'b0, 0, 1'b1);
        frames[6]  = make_frame(rand_byte(), 1'b0, 0, 1'b1);
        frames[7]  = make_frame(8'h80, 1'b0, 0, 1'b1);
        frames[8]  = make_frame(rand_byte(), 1'b0, 0, 1'b1);
        // Bad stop bit between two good frames
        frames[9]  = make_frame(8'h3c, 1'b0, 2, 1'b1);
        frames[10] = make_frame(8'h81, 1'b1, 1, 1'b0);
        frames[11] = make_frame(8'h7e, 1'b0, 2, 1'b1);
        // Edge-case patterns
        frames[12] = make_frame(8'h00, 1'b0, 1, 1'b1);
        frames[13] = make_frame(8'hff, 1'b0, 0, 1'b1);
        frames[14] = make_frame(8'h55, 1'b0, 0, 1'b1);
        frames[15] = make_frame(8'haa, 1'b0, 0, 1'b1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Serial monitor
    //////////////////////////////////////////////////////////////////////

    // Samples on falling clock edges, mid-bit and clear of txd updates
    initial begin
        uart_byte_t got;
        uart_byte_t exp;
        int         i;
        wait (reset == 1'b0);
        forever begin
            @(negedge txd);
            repeat (clks_per_bit / 2) @(negedge clk_50Mhz);
            check_level(txd, start_level, "start bit on txd");
            for (i = 0; i < data_bits; i++) begin
                repeat (clks_per_bit) @(negedge clk_50Mhz);
                got[i] = txd;
            end
            repeat (clks_per_bit) @(negedge clk_50Mhz);
            check_level(txd, stop_level, "stop bit on txd");
            if (expected_q.size() == 0) begin
                stop_on_error("an echo came out with no frame waiting for one");
            end else begin
                exp = expected_q.pop_front();
                check_byte(got, exp, "echoed byte");
            end
            echo_count++;
        end
    end

    // Watchdog, armed once the run length is known
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Watchdog expired after %0d ns with %0d of %0d echoes seen",
                 limit_ns, echo_count, expected_total);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int     i;
        int     drain_cycles;
        longint total_bits;
        rxd = line_idle;
        build_table();
        total_bits = 2 * idle_bits;
        for (i = 0; i < num_frames; i++) begin
            total_bits += frames[i].gap + frame_bits + 1;
            if (frames[i].echo) begin
                expected_total++;
            end
        end
        limit_ns = 3 * total_bits * clks_per_bit * clk_period_ns;

        wait (reset == 1'b0);
        // Quiet line, no echo may appear
        repeat (idle_bits * clks_per_bit) begin
            @(negedge clk_50Mhz);
            check_level(txd, line_idle, "txd while idle");
        end
        check_count(echo_count, 0, "echoes during idle");

        for (i = 0; i < num_frames; i++) begin
            send_frame(frames[i]);
        end

        // Last echo ends about one frame after the last stop bit
        drain_cycles = 0;
        while (echo_count < expected_total && drain_cycles < drain_limit) begin
            @(posedge clk_50Mhz);
            drain_cycles++;
        end
        // Extra time to catch a stray frame
        repeat (2 * frame_bits * clks_per_bit) @(posedge clk_50Mhz);
        check_count(echo_count, expected_total, "echoed frames at end");

        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/uart_pkg.sv
design/uart_rx.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_loopback.sv
dv/clock_gen.sv
dv/tb_uart_loopback.sv
